/* src/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Datapath width, one word
`define XLEN 32

// Registers in each file
`define NREGS 32

// Register index width
`define REG_W 5

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

/* src/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    // Major opcode classes, instruction bits 6:2
    typedef enum logic [4:0] {
        OPC_LOAD      = 5'b00000,
        OPC_FP_LOAD   = 5'b00001,
        OPC_ARI_ITYPE = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_STORE     = 5'b01000,
        OPC_FP_STORE  = 5'b01001,
        OPC_ARI_RTYPE = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_FP_MADD   = 5'b10000,
        OPC_FP        = 5'b10100,
        OPC_BRANCH    = 5'b11000,
        OPC_JALR      = 5'b11001,
        OPC_JAL       = 5'b11011,
        OPC_CSR       = 5'b11100
    } opc5_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_CSR,
        IMM_NONE
    } imm_sel_e;

    // funct7 of the OP-FP instructions we decode
    localparam logic [6:0] FNC7_FP_ADD     = 7'b0000000;
    localparam logic [6:0] FNC7_FP_FSGNJ_S = 7'b0010000;
    localparam logic [6:0] FNC7_FP_MV_X_W  = 7'b1110000;
    localparam logic [6:0] FNC7_FP_MV_W_X  = 7'b1111000;
    localparam logic [6:0] FNC7_FP_CVT_S_W = 7'b1101000;

    // Register-source CSR access
    localparam logic [2:0] FNC_CSRRW = 3'b001;

endpackage

`default_nettype wire

/* src/id_control.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_params.svh"

module id_control (
    input  wire logic [`XLEN-1:0]   inst,
    input  wire logic [`XLEN-1:0]   ex_inst,
    input  wire logic [`XLEN-1:0]   ex_fp_inst,
    input  wire logic               fpu_busy,
    output decode_pkg::imm_sel_e    imm_sel,
    output logic                    stall,
    output logic                    id_ex_stall,
    output logic                    fpu_valid
);

    decode_pkg::opc5_e opc;
    decode_pkg::opc5_e ex_opc;
    decode_pkg::opc5_e fp_opc;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [`REG_W-1:0] rs1;
    logic [`REG_W-1:0] rs2;
    logic [`REG_W-1:0] ex_rd;
    logic [`REG_W-1:0] ex_fd;
    logic              has_rs1;
    logic              has_rs2;
    logic              has_fs1;
    logic              has_fs2;
    logic              rs1_used;
    logic              rs2_used;
    logic              ex_has_rd;
    logic              ex_is_flw;
    logic              fp_has_fd;
    logic              ex_has_fd;
    logic              fpu_inst;

    assign opc    = decode_pkg::opc5_e'(inst[6:2]);
    assign ex_opc = decode_pkg::opc5_e'(ex_inst[6:2]);
    assign fp_opc = decode_pkg::opc5_e'(ex_fp_inst[6:2]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign ex_rd  = ex_inst[11:7];

    // Sources actually read by the ID instruction
    always_comb begin
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        has_fs1 = 1'b0;
        has_fs2 = 1'b0;
        case (opc)
            decode_pkg::OPC_LOAD, decode_pkg::OPC_FP_LOAD, decode_pkg::OPC_ARI_ITYPE,
            decode_pkg::OPC_JALR: begin
                has_rs1 = 1'b1;
            end
            decode_pkg::OPC_STORE, decode_pkg::OPC_BRANCH, decode_pkg::OPC_ARI_RTYPE: begin
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
            end
            decode_pkg::OPC_FP_STORE: begin
                has_rs1 = 1'b1;
                has_fs2 = 1'b1;
            end
            decode_pkg::OPC_CSR: begin
                has_rs1 = (funct3 == decode_pkg::FNC_CSRRW);
            end
            decode_pkg::OPC_FP_MADD: begin
                has_fs1 = 1'b1;
                has_fs2 = 1'b1;
            end
            decode_pkg::OPC_FP: begin
                has_rs1 = (funct7 == decode_pkg::FNC7_FP_MV_W_X) ||
                          (funct7 == decode_pkg::FNC7_FP_CVT_S_W);
                has_fs1 = (funct7 == decode_pkg::FNC7_FP_MV_X_W) ||
                          (funct7 == decode_pkg::FNC7_FP_FSGNJ_S) ||
                          (funct7 == decode_pkg::FNC7_FP_ADD);
                has_fs2 = (funct7 == decode_pkg::FNC7_FP_FSGNJ_S) ||
                          (funct7 == decode_pkg::FNC7_FP_ADD);
            end
            default: ;
        endcase
    end

    // x0 is never a dependence
    assign rs1_used = has_rs1 && (rs1 != '0);
    assign rs2_used = has_rs2 && (rs2 != '0);

    // Integer destination of the instruction in EX
    always_comb begin
        case (ex_opc)
            decode_pkg::OPC_LOAD, decode_pkg::OPC_ARI_ITYPE, decode_pkg::OPC_AUIPC,
            decode_pkg::OPC_ARI_RTYPE, decode_pkg::OPC_LUI, decode_pkg::OPC_JALR,
            decode_pkg::OPC_JAL: ex_has_rd = 1'b1;
            decode_pkg::OPC_FP: ex_has_rd = (ex_inst[31:25] == decode_pkg::FNC7_FP_MV_X_W);
            default: ex_has_rd = 1'b0;
        endcase
    end

    // Pending FP destination, FLW in EX first, then the FPU
    assign ex_is_flw = (ex_opc == decode_pkg::OPC_FP_LOAD);
    assign fp_has_fd = (fp_opc == decode_pkg::OPC_FP_MADD) ||
                       ((fp_opc == decode_pkg::OPC_FP) &&
                        (ex_fp_inst[31:25] != decode_pkg::FNC7_FP_MV_X_W));
    assign ex_has_fd = ex_is_flw || fp_has_fd;
    assign ex_fd     = ex_is_flw ? ex_inst[11:7] : ex_fp_inst[11:7];

    assign stall = (ex_has_rd && ((rs1_used && rs1 == ex_rd) || (rs2_used && rs2 == ex_rd))) ||
                   (ex_has_fd && ((has_fs1 && rs1 == ex_fd) || (has_fs2 && rs2 == ex_fd)));

    // FPU structural hazard
    assign fpu_inst    = (opc == decode_pkg::OPC_FP) || (opc == decode_pkg::OPC_FP_MADD);
    assign id_ex_stall = fpu_inst && fpu_busy;
    assign fpu_valid   = fpu_inst && !fpu_busy;

    always_comb begin
        case (opc)
            decode_pkg::OPC_LOAD, decode_pkg::OPC_FP_LOAD, decode_pkg::OPC_ARI_ITYPE,
            decode_pkg::OPC_JALR: imm_sel = decode_pkg::IMM_I;
            decode_pkg::OPC_STORE, decode_pkg::OPC_FP_STORE: imm_sel = decode_pkg::IMM_S;
            decode_pkg::OPC_BRANCH: imm_sel = decode_pkg::IMM_B;
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: imm_sel = decode_pkg::IMM_U;
            decode_pkg::OPC_JAL: imm_sel = decode_pkg::IMM_J;
            decode_pkg::OPC_CSR: imm_sel = decode_pkg::IMM_CSR;
            default: imm_sel = decode_pkg::IMM_NONE;
        endcase
    end

endmodule

`default_nettype wire

/* src/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_params.svh"

module imm_gen (
    input  wire logic [`XLEN-1:0]       inst,
    input  wire decode_pkg::imm_sel_e   imm_sel,
    output logic [`XLEN-1:0]            imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_sel)
            decode_pkg::IMM_I: begin
                imm = {{(`XLEN-12){sign}}, inst[31:20]};
            end
            decode_pkg::IMM_S: begin
                imm = {{(`XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            // Branch offsets are in half-words
            decode_pkg::IMM_B: begin
                imm = {{(`XLEN-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            decode_pkg::IMM_U: begin
                imm = {inst[31:12], 12'b0};
            end
            decode_pkg::IMM_J: begin
                imm = {{(`XLEN-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            // uimm field of the CSR immediate forms
            decode_pkg::IMM_CSR: begin
                imm = {{(`XLEN-5){1'b0}}, inst[19:15]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_params.svh"

module reg_file #(
    parameter bit ZERO_REG = 1'b1
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               we,
    input  wire logic [`REG_W-1:0]  waddr,
    input  wire logic [`XLEN-1:0]   wdata,
    input  wire logic [`REG_W-1:0]  raddr1,
    input  wire logic [`REG_W-1:0]  raddr2,
    output logic [`XLEN-1:0]        rdata1,
    output logic [`XLEN-1:0]        rdata2
);

    logic [`XLEN-1:0] regs [`NREGS];
    logic             wr_en;

    // x0 writes dropped when hard-wired
    assign wr_en = we && !(ZERO_REG && waddr == '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[waddr] <= wdata;
        end
    end

    // No write-to-read bypass
    assign rdata1 = (ZERO_REG && raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (ZERO_REG && raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* src/id_ex_regs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_params.svh"

module id_ex_regs (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               accept,
    input  wire logic               fp_issue,
    input  wire logic               fpu_busy,
    input  wire logic [`XLEN-1:0]   id_inst,
    input  wire logic [`XLEN-1:0]   id_imm,
    input  wire logic [`XLEN-1:0]   id_rs1_data,
    input  wire logic [`XLEN-1:0]   id_rs2_data,
    input  wire logic [`XLEN-1:0]   id_fs1_data,
    input  wire logic [`XLEN-1:0]   id_fs2_data,
    output logic [`XLEN-1:0]        ex_inst,
    output logic [`XLEN-1:0]        ex_imm,
    output logic [`XLEN-1:0]        ex_rs1_data,
    output logic [`XLEN-1:0]        ex_rs2_data,
    output logic [`XLEN-1:0]        ex_fs1_data,
    output logic [`XLEN-1:0]        ex_fs2_data,
    output logic [`XLEN-1:0]        ex_fp_inst,
    output logic                    fpu_valid_q
);

    // Bubble when nothing is accepted
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_inst <= `NOP_INST;
            ex_imm  <= '0;
        end else if (accept) begin
            ex_inst <= id_inst;
            ex_imm  <= id_imm;
        end else begin
            ex_inst <= `NOP_INST;
            ex_imm  <= '0;
        end
    end

    // Operands hold their last value across bubbles
    always_ff @(posedge clk) begin
        if (accept) begin
            ex_rs1_data <= id_rs1_data;
            ex_rs2_data <= id_rs2_data;
            ex_fs1_data <= id_fs1_data;
            ex_fs2_data <= id_fs2_data;
        end
    end

    // Instruction in flight in the FPU
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_fp_inst  <= `NOP_INST;
            fpu_valid_q <= 1'b0;
        end else begin
            fpu_valid_q <= fp_issue;
            if (fp_issue) begin
                ex_fp_inst <= id_inst;
            end else if (!fpu_busy) begin
                ex_fp_inst <= `NOP_INST;
            end
        end
    end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_params.svh"

module decode_stage (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic [`XLEN-1:0]   inst,
    input  wire logic               inst_valid,
    input  wire logic               fpu_busy,
    input  wire logic               wb_we,
    input  wire logic [`REG_W-1:0]  wb_rd,
    input  wire logic [`XLEN-1:0]   wb_data,
    input  wire logic               wb_fp_we,
    input  wire logic [`REG_W-1:0]  wb_fd,
    input  wire logic [`XLEN-1:0]   wb_fp_data,
    output logic                    hold,
    output logic [`XLEN-1:0]        ex_inst,
    output logic [`XLEN-1:0]        ex_imm,
    output logic [`XLEN-1:0]        ex_rs1_data,
    output logic [`XLEN-1:0]        ex_rs2_data,
    output logic [`XLEN-1:0]        ex_fs1_data,
    output logic [`XLEN-1:0]        ex_fs2_data,
    output logic [`XLEN-1:0]        ex_fp_inst,
    output logic                    fpu_valid_q
);

    logic [`XLEN-1:0]     id_inst;
    logic [`XLEN-1:0]     id_imm;
    logic [`XLEN-1:0]     rs1_data;
    logic [`XLEN-1:0]     rs2_data;
    logic [`XLEN-1:0]     fs1_data;
    logic [`XLEN-1:0]     fs2_data;
    decode_pkg::imm_sel_e imm_sel;
    logic                 stall;
    logic                 id_ex_stall;
    logic                 fpu_valid;
    logic                 accept;
    logic                 fp_issue;

    // Invalid slot decodes as a NOP
    assign id_inst  = inst_valid ? inst : `NOP_INST;
    assign hold     = stall || id_ex_stall;
    assign accept   = inst_valid && !hold;
    assign fp_issue = accept && fpu_valid;

    id_control u_id_control (
        .inst        (id_inst),
        .ex_inst     (ex_inst),
        .ex_fp_inst  (ex_fp_inst),
        .fpu_busy    (fpu_busy),
        .imm_sel     (imm_sel),
        .stall       (stall),
        .id_ex_stall (id_ex_stall),
        .fpu_valid   (fpu_valid)
    );

    imm_gen u_imm_gen (
        .inst    (id_inst),
        .imm_sel (imm_sel),
        .imm     (id_imm)
    );

    reg_file #(.ZERO_REG(1'b1)) int_rf (
        .clk    (clk),
        .reset  (reset),
        .we     (wb_we),
        .waddr  (wb_rd),
        .wdata  (wb_data),
        .raddr1 (id_inst[19:15]),
        .raddr2 (id_inst[24:20]),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // f0 is an ordinary register
    reg_file #(.ZERO_REG(1'b0)) fp_rf (
        .clk    (clk),
        .reset  (reset),
        .we     (wb_fp_we),
        .waddr  (wb_fd),
        .wdata  (wb_fp_data),
        .raddr1 (id_inst[19:15]),
        .raddr2 (id_inst[24:20]),
        .rdata1 (fs1_data),
        .rdata2 (fs2_data)
    );

    id_ex_regs u_id_ex_regs (
        .clk         (clk),
        .reset       (reset),
        .accept      (accept),
        .fp_issue    (fp_issue),
        .fpu_busy    (fpu_busy),
        .id_inst     (id_inst),
        .id_imm      (id_imm),
        .id_rs1_data (rs1_data),
        .id_rs2_data (rs2_data),
        .id_fs1_data (fs1_data),
        .id_fs2_data (fs2_data),
        .ex_inst     (ex_inst),
        .ex_imm      (ex_imm),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_fs1_data (ex_fs1_data),
        .ex_fs2_data (ex_fs2_data),
        .ex_fp_inst  (ex_fp_inst),
        .fpu_valid_q (fpu_valid_q)
    );

endmodule

`default_nettype wire

/* dv/decode_assertions.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_params.svh"

module decode_assertions (
    input wire logic               clk,
    input wire logic               reset,
    input wire logic               hold,
    input wire logic               id_ex_stall,
    input wire logic               fpu_valid,
    input wire logic               fpu_busy,
    input wire logic               fp_issue,
    input wire logic               fpu_valid_q,
    input wire logic [`XLEN-1:0]   id_inst,
    input wire logic [`XLEN-1:0]   ex_inst
);

    int fail_count = 0;

    bubble_after_hold: assert property (@(posedge clk) disable iff (reset)
        hold |=> (ex_inst == `NOP_INST))
    else begin
        fail_count++;
        $error("ex_inst is not a bubble one cycle after hold");
    end

    no_hold_on_nop: assert property (@(posedge clk) disable iff (reset)
        (id_inst == `NOP_INST) |-> !hold)
    else begin
        fail_count++;
        $error("hold is high with a NOP in ID");
    end

    // Issue only on a free FPU, structural stall only on a busy one
    issue_or_stall: assert property (@(posedge clk) disable iff (reset)
        !(fpu_valid && id_ex_stall) && !(fpu_valid && fpu_busy) && !(id_ex_stall && !fpu_busy))
    else begin
        fail_count++;
        $error("fpu_valid and id_ex_stall do not match fpu_busy");
    end

    valid_q_follows_issue: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> (fpu_valid_q == $past(fp_issue)))
    else begin
        fail_count++;
        $error("fpu_valid_q does not follow fp_issue");
    end

endmodule

bind decode_stage decode_assertions u_assertions (
    .clk         (clk),
    .reset       (reset),
    .hold        (hold),
    .id_ex_stall (id_ex_stall),
    .fpu_valid   (fpu_valid),
    .fpu_busy    (fpu_busy),
    .fp_issue    (fp_issue),
    .fpu_valid_q (fpu_valid_q),
    .id_inst     (id_inst),
    .ex_inst     (ex_inst)
);

`default_nettype wire

/* dv/decode_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_params.svh"

module decode_tb;

    localparam int ACCEPT_TIMEOUT = 50;

    logic               clk;
    logic               reset;
    logic [`XLEN-1:0]   inst;
    logic               inst_valid;
    logic               fpu_busy;
    logic               wb_we;
    logic [`REG_W-1:0]  wb_rd;
    logic [`XLEN-1:0]   wb_data;
    logic               wb_fp_we;
    logic [`REG_W-1:0]  wb_fd;
    logic [`XLEN-1:0]   wb_fp_data;
    logic               hold;
    logic [`XLEN-1:0]   ex_inst;
    logic [`XLEN-1:0]   ex_imm;
    logic [`XLEN-1:0]   ex_rs1_data;
    logic [`XLEN-1:0]   ex_rs2_data;
    logic [`XLEN-1:0]   ex_fs1_data;
    logic [`XLEN-1:0]   ex_fs2_data;
    logic [`XLEN-1:0]   ex_fp_inst;
    logic               fpu_valid_q;

    // Expected EX-side state and shadow register files
    logic [`XLEN-1:0]   m_ex_inst;
    logic [`XLEN-1:0]   m_ex_imm;
    logic [`XLEN-1:0]   m_ex_fp;
    logic               m_valid_q;
    logic [`XLEN-1:0]   m_rs1;
    logic [`XLEN-1:0]   m_rs2;
    logic [`XLEN-1:0]   m_fs1;
    logic [`XLEN-1:0]   m_fs2;
    logic               ops_known = 1'b0;
    logic [`XLEN-1:0]   shadow_int [`NREGS];
    logic [`XLEN-1:0]   shadow_fp [`NREGS];
    int                 error_count = 0;
    logic [31:0]        lfsr_state = 32'd77486;

    // Every class, then two unused major opcodes
    logic [4:0] op_list [16] = '{
        decode_pkg::OPC_LOAD, decode_pkg::OPC_FP_LOAD, decode_pkg::OPC_ARI_ITYPE,
        decode_pkg::OPC_AUIPC, decode_pkg::OPC_STORE, decode_pkg::OPC_FP_STORE,
        decode_pkg::OPC_ARI_RTYPE, decode_pkg::OPC_LUI, decode_pkg::OPC_FP_MADD,
        decode_pkg::OPC_FP, decode_pkg::OPC_BRANCH, decode_pkg::OPC_JALR,
        decode_pkg::OPC_JAL, decode_pkg::OPC_CSR, 5'b00010, 5'b11010
    };

    decode_stage UUT (
        .clk         (clk),
        .reset       (reset),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .fpu_busy    (fpu_busy),
        .wb_we       (wb_we),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .wb_fp_we    (wb_fp_we),
        .wb_fd       (wb_fd),
        .wb_fp_data  (wb_fp_data),
        .hold        (hold),
        .ex_inst     (ex_inst),
        .ex_imm      (ex_imm),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_fs1_data (ex_fs1_data),
        .ex_fs2_data (ex_fs2_data),
        .ex_fp_inst  (ex_fp_inst),
        .fpu_valid_q (fpu_valid_q)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [`XLEN-1:0] encode(input decode_pkg::opc5_e op,
            input logic [4:0] rd, input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [6:0] f7);
        return {f7, rs2, rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic logic fp_class(input logic [`XLEN-1:0] w);
        return (w[6:2] == decode_pkg::OPC_FP) || (w[6:2] == decode_pkg::OPC_FP_MADD);
    endfunction

    function automatic void ref_decode(input logic [`XLEN-1:0] w,
            input logic [`XLEN-1:0] ex_w, input logic [`XLEN-1:0] fp_w, input logic busy,
            output logic exp_hold, output logic [`XLEN-1:0] exp_imm,
            output decode_pkg::imm_sel_e exp_sel);
        logic signed [`XLEN-1:0] sx;
        logic [3:0]              src;
        logic [6:0]              f7;
        logic                    int_wr;
        logic                    fp_pend;
        logic                    raw;
        logic [4:0]              fd;
        decode_pkg::opc5_e       ex_op;
        decode_pkg::opc5_e       fp_op;
        f7 = w[31:25];
        src = 4'b0000;
        sx = '0;
        exp_sel = decode_pkg::IMM_NONE;
        // src is {rs1, rs2, fs1, fs2}
        case (decode_pkg::opc5_e'(w[6:2]))
            decode_pkg::OPC_LOAD, decode_pkg::OPC_FP_LOAD, decode_pkg::OPC_ARI_ITYPE,
            decode_pkg::OPC_JALR: begin
                src = 4'b1000;
                exp_sel = decode_pkg::IMM_I;
                sx = $signed(w[31:20]);
            end
            decode_pkg::OPC_STORE, decode_pkg::OPC_FP_STORE: begin
                src = (w[6:2] == decode_pkg::OPC_STORE) ? 4'b1100 : 4'b1001;
                exp_sel = decode_pkg::IMM_S;
                sx = $signed({w[31:25], w[11:7]});
            end
            decode_pkg::OPC_BRANCH: begin
                src = 4'b1100;
                exp_sel = decode_pkg::IMM_B;
                sx = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            end
            decode_pkg::OPC_ARI_RTYPE: src = 4'b1100;
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
                exp_sel = decode_pkg::IMM_U;
                sx = {w[31:12], 12'b0};
            end
            decode_pkg::OPC_JAL: begin
                exp_sel = decode_pkg::IMM_J;
                sx = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            end
            decode_pkg::OPC_CSR: begin
                src = {w[14:12] == decode_pkg::FNC_CSRRW, 3'b000};
                exp_sel = decode_pkg::IMM_CSR;
                sx = {27'b0, w[19:15]};
            end
            decode_pkg::OPC_FP_MADD: src = 4'b0011;
            decode_pkg::OPC_FP: begin
                src[3] = (f7 == decode_pkg::FNC7_FP_MV_W_X) || (f7 == decode_pkg::FNC7_FP_CVT_S_W);
                src[0] = (f7 == decode_pkg::FNC7_FP_ADD) || (f7 == decode_pkg::FNC7_FP_FSGNJ_S);
                src[1] = src[0] || (f7 == decode_pkg::FNC7_FP_MV_X_W);
            end
            default: ;
        endcase
        exp_imm = sx;
        ex_op = decode_pkg::opc5_e'(ex_w[6:2]);
        fp_op = decode_pkg::opc5_e'(fp_w[6:2]);
        int_wr = (ex_op inside {decode_pkg::OPC_LOAD, decode_pkg::OPC_ARI_ITYPE,
                  decode_pkg::OPC_AUIPC, decode_pkg::OPC_ARI_RTYPE, decode_pkg::OPC_LUI,
                  decode_pkg::OPC_JALR, decode_pkg::OPC_JAL}) ||
                 (ex_op == decode_pkg::OPC_FP && ex_w[31:25] == decode_pkg::FNC7_FP_MV_X_W);
        if (ex_op == decode_pkg::OPC_FP_LOAD) begin
            fp_pend = 1'b1;
            fd = ex_w[11:7];
        end else begin
            fp_pend = (fp_op == decode_pkg::OPC_FP_MADD) ||
                      (fp_op == decode_pkg::OPC_FP && fp_w[31:25] != decode_pkg::FNC7_FP_MV_X_W);
            fd = fp_w[11:7];
        end
        raw = int_wr && ((src[3] && w[19:15] != 0 && w[19:15] == ex_w[11:7]) ||
                         (src[2] && w[24:20] != 0 && w[24:20] == ex_w[11:7]));
        raw = raw || (fp_pend && ((src[1] && w[19:15] == fd) || (src[0] && w[24:20] == fd)));
        exp_hold = raw || (fp_class(w) && busy);
    endfunction

    task automatic report_error(input string line);
        error_count++;
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input logic [`XLEN-1:0] act, input logic [`XLEN-1:0] exp,
            input string what);
        if (act !== exp) begin
            report_error($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                   $time, what, act, exp));
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            report_error($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                   $time, what, act, exp));
        end
    endtask

    task automatic check_imm_sel(input decode_pkg::imm_sel_e act,
            input decode_pkg::imm_sel_e exp, input string what);
        if (act !== exp) begin
            report_error($sformatf("Mismatch at %0t ns: %s is %s, expected %s",
                                   $time, what, act.name(), exp.name()));
        end
    endtask

    task automatic check_count(input int act, input int exp, input string what);
        if (act != exp) begin
            report_error($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                                   $time, what, act, exp));
        end
    endtask

    // Called 5 ns after a rising edge, returns 5 ns after the accepting edge
    task automatic issue(input logic [`XLEN-1:0] word, input int busy_cycles,
            output int held);
        inst = word;
        inst_valid = 1'b1;
        fpu_busy = (busy_cycles > 0);
        held = 0;
        @(negedge clk);
        while (hold) begin
            if (held == ACCEPT_TIMEOUT) begin
                report_error($sformatf("Timed out at %0t ns: instruction %h never accepted",
                                       $time, word));
            end
            @(posedge clk);
            #5;
            held++;
            if (held >= busy_cycles) begin
                fpu_busy = 1'b0;
            end
            @(negedge clk);
        end
        @(posedge clk);
        #5;
        inst = `NOP_INST;
        inst_valid = 1'b0;
        fpu_busy = 1'b0;
    endtask

    task automatic write_back(input logic we, input logic [4:0] rd, input logic [31:0] data,
            input logic fp_we, input logic [4:0] fd, input logic [31:0] fp_data);
        wb_we = we;
        wb_rd = rd;
        wb_data = data;
        wb_fp_we = fp_we;
        wb_fd = fd;
        wb_fp_data = fp_data;
        @(posedge clk);
        #5;
        wb_we = 1'b0;
        wb_fp_we = 1'b0;
    endtask

    // Compare at the falling edge, then step the model to the next rising edge
    always @(negedge clk) begin
        logic [`XLEN-1:0]     idw;
        logic [`XLEN-1:0]     e_imm;
        logic                 e_hold;
        logic                 acc;
        decode_pkg::imm_sel_e e_sel;
        if (reset !== 1'b0) begin
            m_ex_inst = `NOP_INST;
            m_ex_imm = '0;
            m_ex_fp = `NOP_INST;
            m_valid_q = 1'b0;
        end else begin
            if (UUT.u_assertions.fail_count != 0) begin
                report_error("An assertion on the decode stage failed");
            end
            idw = inst_valid ? inst : `NOP_INST;
            ref_decode(idw, m_ex_inst, m_ex_fp, fpu_busy, e_hold, e_imm, e_sel);
            check_bit(hold, e_hold, "hold");
            check_imm_sel(UUT.imm_sel, e_sel, "imm_sel");
            check_word(ex_inst, m_ex_inst, "ex_inst");
            check_word(ex_imm, m_ex_imm, "ex_imm");
            check_word(ex_fp_inst, m_ex_fp, "ex_fp_inst");
            check_bit(fpu_valid_q, m_valid_q, "fpu_valid_q");
            if (ops_known) begin
                check_word(ex_rs1_data, m_rs1, "ex_rs1_data");
                check_word(ex_rs2_data, m_rs2, "ex_rs2_data");
                check_word(ex_fs1_data, m_fs1, "ex_fs1_data");
                check_word(ex_fs2_data, m_fs2, "ex_fs2_data");
            end
            acc = inst_valid && !e_hold;
            m_valid_q = acc && fp_class(idw);
            if (m_valid_q) begin
                m_ex_fp = idw;
            end else if (!fpu_busy) begin
                m_ex_fp = `NOP_INST;
            end
            m_ex_inst = acc ? idw : `NOP_INST;
            m_ex_imm = acc ? e_imm : '0;
            if (acc) begin
                m_rs1 = (idw[19:15] == 0) ? '0 : shadow_int[idw[19:15]];
                m_rs2 = (idw[24:20] == 0) ? '0 : shadow_int[idw[24:20]];
                m_fs1 = shadow_fp[idw[19:15]];
                m_fs2 = shadow_fp[idw[24:20]];
                ops_known = 1'b1;
            end
            if (wb_we && wb_rd != 0) begin
                shadow_int[wb_rd] = wb_data;
            end
            if (wb_fp_we) begin
                shadow_fp[wb_fd] = wb_fp_data;
            end
        end
    end

    initial begin
        int               held;
        int               k;
        logic [`XLEN-1:0] word;
        logic [`XLEN-1:0] f0_val;
        reset = 1'b1;
        inst = `NOP_INST;
        inst_valid = 1'b0;
        fpu_busy = 1'b0;
        wb_we = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        wb_fp_we = 1'b0;
        wb_fd = '0;
        wb_fp_data = '0;
        repeat (5) @(posedge clk);
        #5;
        reset = 1'b0;
        check_word(ex_inst, `NOP_INST, "ex_inst after reset");
        check_word(ex_fp_inst, `NOP_INST, "ex_fp_inst after reset");
        check_word(ex_imm, '0, "ex_imm after reset");
        check_bit(fpu_valid_q, 1'b0, "fpu_valid_q after reset");
        @(negedge clk);
        check_bit(hold, 1'b0, "hold after reset");
        @(posedge clk);
        #5;

        // Fill both files so every operand has a known value
        for (k = 0; k < `NREGS; k++) begin
            write_back(1'b1, k[4:0], rand_bits(32), 1'b1, k[4:0], rand_bits(32));
        end

        for (k = 0; k < 64; k++) begin
            word = {25'(rand_bits(25)), op_list[k % 16], 2'b11};
            issue(word, 0, held);
        end

        // Integer RAW and load-use
        issue(encode(decode_pkg::OPC_ARI_ITYPE, 5'd5, 3'd0, 5'd0, 5'd12, 7'd0), 0, held);
        issue(encode(decode_pkg::OPC_ARI_RTYPE, 5'd7, 3'd0, 5'd5, 5'd6, 7'd0), 0, held);
        check_count(held, 1, "held cycles for add after addi");
        issue(encode(decode_pkg::OPC_LOAD, 5'd9, 3'd2, 5'd0, 5'd0, 7'd0), 0, held);
        issue(encode(decode_pkg::OPC_STORE, 5'd4, 3'd2, 5'd2, 5'd9, 7'd0), 0, held);
        check_count(held, 1, "held cycles for sw after lw");
        issue(encode(decode_pkg::OPC_ARI_ITYPE, 5'd0, 3'd0, 5'd0, 5'd5, 7'd0), 0, held);
        issue(encode(decode_pkg::OPC_ARI_RTYPE, 5'd3, 3'd0, 5'd0, 5'd0, 7'd0), 0, held);
        check_count(held, 0, "held cycles for x0 pair");
        issue(encode(decode_pkg::OPC_ARI_ITYPE, 5'd5, 3'd0, 5'd0, 5'd1, 7'd0), 0, held);
        issue(encode(decode_pkg::OPC_LUI, 5'd6, 3'd0, 5'd5, 5'd5, 7'd0), 0, held);
        check_count(held, 0, "held cycles for lui");
        issue(encode(decode_pkg::OPC_ARI_ITYPE, 5'd5, 3'd0, 5'd0, 5'd2, 7'd0), 0, held);
        issue(encode(decode_pkg::OPC_JAL, 5'd1, 3'd0, 5'd5, 5'd5, 7'd0), 0, held);
        check_count(held, 0, "held cycles for jal");

        // FP hazards
        issue(encode(decode_pkg::OPC_FP_LOAD, 5'd4, 3'd2, 5'd0, 5'd0, 7'd0), 0, held);
        issue(encode(decode_pkg::OPC_FP, 5'd6, 3'd0, 5'd4, 5'd1,
                     decode_pkg::FNC7_FP_ADD), 0, held);
        check_count(held, 1, "held cycles for fadd after flw");
        issue(encode(decode_pkg::OPC_FP_STORE, 5'd8, 3'd2, 5'd0, 5'd6, 7'd0), 3, held);
        check_count(held, 4, "held cycles for fsw behind busy fadd");
        issue(encode(decode_pkg::OPC_FP, 5'd8, 3'd0, 5'd2, 5'd0,
                     decode_pkg::FNC7_FP_MV_X_W), 0, held);
        issue(encode(decode_pkg::OPC_ARI_RTYPE, 5'd9, 3'd0, 5'd8, 5'd0, 7'd0), 0, held);
        check_count(held, 1, "held cycles for add after fmv.x.w");
        issue(encode(decode_pkg::OPC_FP, 5'd8, 3'd0, 5'd2, 5'd0,
                     decode_pkg::FNC7_FP_MV_X_W), 0, held);
        issue(encode(decode_pkg::OPC_FP, 5'd10, 3'd0, 5'd8, 5'd8,
                     decode_pkg::FNC7_FP_ADD), 0, held);
        check_count(held, 0, "held cycles for fadd after fmv.x.w");

        // Structural stall on a busy FPU
        word = encode(decode_pkg::OPC_FP, 5'd11, 3'd0, 5'd1, 5'd2, decode_pkg::FNC7_FP_ADD);
        issue(word, 2, held);
        check_count(held, 2, "held cycles for fadd on busy FPU");
        check_bit(fpu_valid_q, 1'b1, "fpu_valid_q after issue");
        check_word(ex_fp_inst, word, "ex_fp_inst after issue");

        // Operand reads after random writebacks
        for (k = 0; k < 24; k++) begin
            if (k % 3 == 0) begin
                write_back(1'b1, 5'(rand_bits(5)), rand_bits(32),
                           1'b1, 5'(rand_bits(5)), rand_bits(32));
            end
            issue(encode(decode_pkg::OPC_ARI_RTYPE, 5'(rand_bits(5)), 3'd0,
                         5'(rand_bits(5)), 5'(rand_bits(5)), 7'd0), 0, held);
        end
        f0_val = rand_bits(32);
        write_back(1'b1, 5'd0, rand_bits(32), 1'b1, 5'd0, f0_val);
        issue(encode(decode_pkg::OPC_ARI_RTYPE, 5'd3, 3'd0, 5'd0, 5'd0, 7'd0), 0, held);
        check_word(ex_rs1_data, '0, "ex_rs1_data read from x0");
        check_word(ex_fs1_data, f0_val, "ex_fs1_data read from f0");

        repeat (3) @(posedge clk);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+src
src/decode_pkg.sv
src/id_control.sv
src/imm_gen.sv
src/reg_file.sv
src/id_ex_regs.sv
src/decode_stage.sv
dv/decode_assertions.sv
dv/decode_tb.sv
